//--- hw/strm_mux_params.svh
`ifndef STRM_MUX_PARAMS_SVH
`define STRM_MUX_PARAMS_SVH

// Number of producer streams
`define STRM_MUX_N_SRC 4

// Beat data width in bits
`define STRM_MUX_DATA_BITS 64

// Length field holds beats minus one
`define STRM_MUX_LEN_BITS 8

// Queue depths
`define STRM_MUX_CMD_DEPTH 4
`define STRM_MUX_IN_DEPTH 4

`endif

//--- hw/strm_mux_pkg.sv
`include "strm_mux_params.svh"

package strm_mux_pkg;

  // ------------------------------
  // Stream beat
  // ------------------------------
  typedef struct packed {
    logic [`STRM_MUX_DATA_BITS-1:0]   data;
    // One enable per byte
    logic [`STRM_MUX_DATA_BITS/8-1:0] keep;
    // Passed through and never ends a transfer
    logic                             last;
  } beat_t;

  // ------------------------------
  // Routing command
  // ------------------------------
  typedef struct packed {
    // Source index
    logic [7:0]                       dest;
    // Beat count minus one
    logic [`STRM_MUX_LEN_BITS-1:0]    len;
  } mux_cmd_t;

endpackage

//--- hw/fifo_sync.sv
`timescale 1ns/1ps

module fifo_sync import strm_mux_pkg::*; #(
  parameter type payload_t = beat_t,
  parameter int  DEPTH     = 4
) (
  input  logic     aclk,
  input  logic     aresetn,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // Pointer and count widths
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // Storage
  payload_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  // Flags straight from the count
  assign in_ready  = (count != CW'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Write side
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Count holds when push and pop coincide
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/axis_mux_user_wr.sv
`timescale 1ns/1ps

`include "strm_mux_params.svh"

module axis_mux_user_wr import strm_mux_pkg::*; #(
  parameter int N_SRC = 4
) (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  mux_cmd_t             cmd,
  input  logic     [N_SRC-1:0] s_valid,
  output logic     [N_SRC-1:0] s_ready,
  input  beat_t    [N_SRC-1:0] s_beat,
  output logic                 m_valid,
  input  logic                 m_ready,
  output beat_t                m_beat
);

  // Select width of at least one bit
  localparam int SEL_BITS = (N_SRC > 1) ? $clog2(N_SRC) : 1;

  typedef enum logic [0:0] {ST_IDLE, ST_FWD} state_t;

  state_t                        state_q, state_d;
  logic [SEL_BITS-1:0]           dest_q, dest_d;
  logic [`STRM_MUX_LEN_BITS-1:0] cnt_q, cnt_d;

  logic fwd;
  logic m_hs;
  logic tr_done;

  // ------------------------------
  // Data path select
  // ------------------------------
  assign fwd = (state_q == ST_FWD);

  always_comb begin
    // Only the chosen source sees ready
    for (int i = 0; i < N_SRC; i++) begin
      s_ready[i] = fwd && (int'(dest_q) == i) && m_ready;
    end

    if (fwd && (int'(dest_q) < N_SRC)) begin
      m_valid = s_valid[dest_q];
      m_beat  = s_beat[dest_q];
    end else begin
      // Quiet output while idle
      m_valid = 1'b0;
      m_beat  = '0;
    end
  end

  assign m_hs = m_valid & m_ready;

  // Last counted beat moving this cycle
  assign tr_done = fwd && (cnt_q == '0) && m_hs;

  // ------------------------------
  // Next state and counters
  // ------------------------------
  always_comb begin
    state_d   = state_q;
    dest_d    = dest_q;
    cnt_d     = cnt_q;
    cmd_ready = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (cmd_valid) begin
          cmd_ready = 1'b1;
          state_d   = ST_FWD;
          dest_d    = cmd.dest[SEL_BITS-1:0];
          cnt_d     = cmd.len;
        end
      end

      ST_FWD: begin
        if (tr_done) begin
          // Chain straight into the next command without a bubble
          if (cmd_valid) begin
            cmd_ready = 1'b1;
            dest_d    = cmd.dest[SEL_BITS-1:0];
            cnt_d     = cmd.len;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (m_hs) begin
          cnt_d = cnt_q - 1'b1;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      dest_q  <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      dest_q  <= dest_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

//--- hw/beat_reg_slice.sv
`timescale 1ns/1ps

module beat_reg_slice import strm_mux_pkg::*; (
  input  logic  aclk,
  input  logic  aresetn,
  input  logic  in_valid,
  output logic  in_ready,
  input  beat_t in_beat,
  output logic  out_valid,
  input  logic  out_ready,
  output beat_t out_beat
);

  // Spare entry catches one beat while output stalls
  beat_t spare_beat;
  logic  spare_valid;
  logic  out_free;
  logic  in_hs;

  // Ready comes from a flop only
  assign in_ready = ~spare_valid;
  assign out_free = ~out_valid | out_ready;
  assign in_hs    = in_valid & in_ready;

  // ------------------------------
  // Control
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
    end else if (out_free) begin
      // Drain spare first and otherwise take input directly
      out_valid   <= spare_valid | in_valid;
      spare_valid <= 1'b0;
    end else if (in_hs) begin
      spare_valid <= 1'b1;
    end
  end

  // ------------------------------
  // Payload
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (out_free) begin
      if (spare_valid) begin
        out_beat <= spare_beat;
      end else if (in_valid) begin
        out_beat <= in_beat;
      end
    end else if (in_hs) begin
      spare_beat <= in_beat;
    end
  end

endmodule

//--- hw/strm_mux_top.sv
`timescale 1ns/1ps

`include "strm_mux_params.svh"

module strm_mux_top import strm_mux_pkg::*; (
  input  logic                              aclk,
  input  logic                              aresetn,
  // Routing commands
  input  logic                              cmd_valid,
  output logic                              cmd_ready,
  input  mux_cmd_t                          cmd,
  // Producer streams
  input  logic     [`STRM_MUX_N_SRC-1:0]    src_valid,
  output logic     [`STRM_MUX_N_SRC-1:0]    src_ready,
  input  beat_t    [`STRM_MUX_N_SRC-1:0]    src,
  // Merged stream
  output logic                              out_valid,
  input  logic                              out_ready,
  output beat_t                             out
);

  // Queued commands
  logic     q_cmd_valid;
  logic     q_cmd_ready;
  mux_cmd_t q_cmd;

  // Buffered sources
  logic  [`STRM_MUX_N_SRC-1:0] buf_valid;
  logic  [`STRM_MUX_N_SRC-1:0] buf_ready;
  beat_t [`STRM_MUX_N_SRC-1:0] buf_beat;

  // Mux to slice
  logic  mux_valid;
  logic  mux_ready;
  beat_t mux_beat;

  // ------------------------------
  // Input side
  // ------------------------------
  fifo_sync #(.payload_t(mux_cmd_t), .DEPTH(`STRM_MUX_CMD_DEPTH)) u_cmd_fifo (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd),
    .out_valid(q_cmd_valid), .out_ready(q_cmd_ready), .out_data(q_cmd)
  );

  // One buffer per source
  for (genvar i = 0; i < `STRM_MUX_N_SRC; i++) begin : g_src
    fifo_sync #(.payload_t(beat_t), .DEPTH(`STRM_MUX_IN_DEPTH)) u_src_fifo (
      .aclk(aclk), .aresetn(aresetn),
      .in_valid(src_valid[i]), .in_ready(src_ready[i]), .in_data(src[i]),
      .out_valid(buf_valid[i]), .out_ready(buf_ready[i]), .out_data(buf_beat[i])
    );
  end

  // ------------------------------
  // Processing and output side
  // ------------------------------
  axis_mux_user_wr #(.N_SRC(`STRM_MUX_N_SRC)) u_mux (
    .aclk(aclk), .aresetn(aresetn),
    .cmd_valid(q_cmd_valid), .cmd_ready(q_cmd_ready), .cmd(q_cmd),
    .s_valid(buf_valid), .s_ready(buf_ready), .s_beat(buf_beat),
    .m_valid(mux_valid), .m_ready(mux_ready), .m_beat(mux_beat)
  );

  beat_reg_slice u_slice (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(mux_valid), .in_ready(mux_ready), .in_beat(mux_beat),
    .out_valid(out_valid), .out_ready(out_ready), .out_beat(out)
  );

endmodule

//--- dv/strm_mux_tb.sv
`timescale 1ns/1ps

`include "strm_mux_params.svh"

module strm_mux_tb import strm_mux_pkg::*; ;

  localparam int NS = `STRM_MUX_N_SRC;

  // ------------------------------
  // Test table
  // ------------------------------
  localparam int NT = 6;
  localparam int NC = 31;
  // First command, command count, out_ready and gap percentages, start delays
  localparam int T_FIRST [NT] = '{0, 2, 6, 12, 17, 21};
  localparam int T_NCMD  [NT] = '{2, 4, 6, 5, 4, 10};
  localparam int T_RDY   [NT] = '{100, 100, 100, 50, 80, 70};
  localparam int T_GAP   [NT] = '{0, 0, 0, 0, 40, 25};
  localparam int T_CDLY  [NT] = '{30, 0, 0, 0, 0, 0};
  localparam int T_SDLY  [NT] = '{0, 0, 0, 0, 40, 0};
  // Command list of all tests back to back
  localparam int C_DEST  [NC] = '{0, 2, 0, 1, 2, 3, 1, 1, 2, 2, 0, 3, 0, 3, 1, 2,
                                  0, 2, 0, 3, 2, 0, 1, 2, 3, 0, 1, 2, 3, 0, 1};
  localparam int C_LEN   [NC] = '{1, 0, 0, 0, 0, 0, 3, 0, 7, 2, 15, 1, 5, 9, 2, 12,
                                  3, 4, 6, 2, 1, 2, 2, 2, 2, 1, 3, 0, 4, 3, 0};

  logic             aclk;
  logic             aresetn;
  logic             cmd_valid;
  logic             cmd_ready;
  mux_cmd_t         cmd;
  logic  [NS-1:0]   src_valid;
  logic  [NS-1:0]   src_ready;
  beat_t [NS-1:0]   src;
  logic             out_valid;
  logic             out_ready;
  beat_t            out;

  // Scoreboard state
  beat_t src_q [NS][$];
  beat_t exp_q [$];
  // Command owning each expected output position
  int    slot_q [$];
  int    got_cnt [NC];
  int    got_dest [NC];
  int    errors;
  int    n_pass;
  int    n_fail;

  strm_mux_top u_dut (
    .aclk, .aresetn, .cmd_valid, .cmd_ready, .cmd,
    .src_valid, .src_ready, .src, .out_valid, .out_ready, .out
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic string test_name(int t);
    case (t)
      0:       return "idle_until_cmd";
      1:       return "single_beat";
      2:       return "multi_len";
      3:       return "backpressure";
      4:       return "late_data";
      default: return "interleave";
    endcase
  endfunction

  // Data is {command seq, source, beat index, marker}
  function automatic beat_t make_beat(int seq, int s, int idx, int len);
    beat_t b;
    b.data = {16'(seq), 16'(s), 16'(idx), 16'hc0de};
    b.keep = '1;
    b.last = (idx == len);
    return b;
  endfunction

  function automatic mux_cmd_t make_cmd(int k);
    mux_cmd_t c;
    c.dest = 8'(C_DEST[k]);
    c.len  = 8'(C_LEN[k]);
    return c;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_beat(beat_t exp, beat_t got);
    if (got !== exp) begin
      $display("ERR @%0t: beat mismatch, expected %h got %h", $time, exp, got);
      errors++;
    end
  endtask

  task automatic check_cmd(int k, mux_cmd_t exp, mux_cmd_t got);
    if (got !== exp) begin
      $display("ERR @%0t: command %0d gave dest %0d len %0d, expected dest %0d len %0d",
               $time, k, got.dest, got.len, exp.dest, exp.len);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge aclk);
    #1;
    aresetn   = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    src_valid = '0;
    src       = '0;
    out_ready = 1'b0;
    repeat (3) @(posedge aclk);
    #1 aresetn = 1'b1;
  endtask

  task automatic run_test(int t);
    int          cyc;
    int          cmd_pos;
    int          seq;
    int          slot;
    int          start_err;
    int          n_beats;
    logic        cmd_moved;
    logic [NS-1:0] moved;
    beat_t       b;
    mux_cmd_t    rec;
    start_err = errors;
    n_beats   = 0;
    // Expected order is command order with len+1 beats each
    for (int s = 0; s < NS; s++) src_q[s].delete();
    exp_q.delete();
    slot_q.delete();
    for (int k = T_FIRST[t]; k < T_FIRST[t] + T_NCMD[t]; k++) begin
      got_cnt[k]  = 0;
      got_dest[k] = -1;
      for (int i = 0; i <= C_LEN[k]; i++) begin
        b = make_beat(k, C_DEST[k], i, C_LEN[k]);
        src_q[C_DEST[k]].push_back(b);
        exp_q.push_back(b);
        slot_q.push_back(k);
      end
    end
    apply_reset();
    cyc     = 0;
    cmd_pos = T_FIRST[t];
    while (exp_q.size() > 0) begin
      // Handshakes settle well before the edge
      @(negedge aclk);
      for (int s = 0; s < NS; s++) begin
        moved[s] = src_valid[s] && src_ready[s];
        if (moved[s]) void'(src_q[s].pop_front());
      end
      if (out_valid && cmd_pos == T_FIRST[t]) begin
        $display("ERR @%0t: output valid before any command was taken", $time);
        errors++;
      end
      cmd_moved = cmd_valid && cmd_ready;
      if (cmd_moved) cmd_pos++;
      if (out_valid && out_ready) begin
        b = out;
        check_beat(exp_q.pop_front(), b);
        slot = slot_q.pop_front();
        n_beats++;
        // Source seen in this command's output slot
        got_dest[slot] = int'(b.data[47:32]);
        seq = int'(b.data[63:48]);
        if (seq < NC) begin
          got_cnt[seq]++;
        end
      end
      @(posedge aclk);
      #1;
      cyc++;
      // Hold a beat until taken or maybe insert a gap
      for (int s = 0; s < NS; s++) begin
        if (!src_valid[s] || moved[s]) begin
          if (cyc >= T_SDLY[t] && src_q[s].size() > 0 &&
              int'($urandom_range(99)) >= T_GAP[t]) begin
            src_valid[s] = 1'b1;
            src[s]       = src_q[s][0];
          end else begin
            src_valid[s] = 1'b0;
          end
        end
      end
      if (!cmd_valid || cmd_moved) begin
        cmd_valid = (cyc >= T_CDLY[t]) && (cmd_pos < T_FIRST[t] + T_NCMD[t]);
        if (cmd_valid) cmd = make_cmd(cmd_pos);
      end
      out_ready = int'($urandom_range(99)) < T_RDY[t];
    end
    // Nothing more may come out
    @(posedge aclk);
    #1;
    src_valid = '0;
    cmd_valid = 1'b0;
    out_ready = 1'b1;
    repeat (10) begin
      @(negedge aclk);
      if (out_valid) begin
        $display("ERR @%0t: extra beat %h after the last transfer", $time, out);
        errors++;
      end
    end
    // Count from the beat encoding and source from the output slots
    for (int k = T_FIRST[t]; k < T_FIRST[t] + T_NCMD[t]; k++) begin
      rec.dest = 8'(got_dest[k]);
      rec.len  = 8'(got_cnt[k] - 1);
      check_cmd(k, make_cmd(k), rec);
    end
    if (errors == start_err) n_pass++;
    else n_fail++;
    $display("Test %0d %s: %s, %0d beats, %0d errors", t, test_name(t),
             (errors == start_err) ? "PASS" : "FAIL", n_beats, errors - start_err);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'had61bbd3));
    errors = 0;
    n_pass = 0;
    n_fail = 0;
    aresetn   = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    src_valid = '0;
    src       = '0;
    out_ready = 1'b0;
    for (int t = 0; t < NT; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per beat plus slack per test
  initial begin : watchdog
    int limit;
    limit = NT * 150;
    for (int k = 0; k < NC; k++) limit += (C_LEN[k] + 1) * 20;
    #(limit * 10);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- strm_mux.f
+incdir+hw
hw/strm_mux_pkg.sv
hw/fifo_sync.sv
hw/axis_mux_user_wr.sv
hw/beat_reg_slice.sv
hw/strm_mux_top.sv
dv/strm_mux_tb.sv

//--- Makefile
TOP := strm_mux_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f strm_mux.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
